//--- tb_core_dec_input.txt
# test enb kill ack inst pc wb_we wb_rd wb_data exp_val exp_rd exp_imm exp_alu exp_we exp_l1d exp_stall
# all fields hex, test 3 wb_data is replaced by lfsr values
1 0 0 1 00000013 00001000 0 00 00000000 0 00 00000000 0 0 0 0
1 0 0 0 00000013 00001000 0 00 00000000 0 00 00000000 0 0 0 1
2 1 0 1 123450b7 00001000 0 00 00000000 1 01 12345000 a 1 0 0
2 1 0 1 fffff117 00001004 0 00 00000000 1 02 fffff000 0 1 0 0
2 1 0 1 ffdff1ef 00001008 0 00 00000000 1 03 fffffffc 0 1 0 0
2 1 0 1 00828267 0000100c 0 00 00000000 1 04 00000008 0 1 0 0
2 1 0 1 00208863 00001010 0 00 00000000 1 10 00000010 1 0 0 0
2 1 0 1 ff83a303 00001014 0 00 00000000 1 06 fffffff8 0 1 1 0
2 1 0 1 0084a623 00001018 0 00 00000000 1 0c 0000000c 0 0 1 0
2 1 0 1 fff5c513 0000101c 0 00 00000000 1 0a ffffffff 5 1 0 0
2 1 0 1 40e68633 00001020 0 00 00000000 1 0c 00000000 1 1 0 0
2 1 0 1 00000000 00001024 0 00 00000000 1 00 00000000 0 0 0 0
3 0 0 1 00000013 00002000 1 05 00000000 0 00 00000000 0 0 0 0
3 1 0 1 006283b3 00002004 1 06 00000000 1 07 00000000 0 1 0 0
3 1 0 1 80000413 00002008 1 00 00000000 1 08 fffff800 0 1 0 0
3 1 0 1 fe62afa3 0000200c 0 00 00000000 1 1f ffffffff 0 0 1 0
3 1 0 1 80629063 00002010 0 00 00000000 1 00 fffff000 1 0 0 0
3 1 0 1 800004b7 00002014 1 1f 00000000 1 09 80000000 a 1 0 0
3 1 0 1 005fe533 00002018 0 00 00000000 1 0a 00000000 8 1 0 0
4 1 1 1 00500093 00003000 0 00 00000000 0 00 00000005 0 0 0 0
4 1 0 1 00500093 00003000 0 00 00000000 1 01 00000005 0 1 0 0
4 0 1 1 00500093 00003004 0 00 00000000 0 00 00000005 0 0 0 0
5 0 0 0 00000013 00004000 0 00 00000000 0 00 00000005 0 0 0 1
5 1 0 1 00012183 00004000 0 00 00000000 1 03 00000000 0 1 1 0
5 1 0 1 00118233 00004004 0 00 00000000 0 00 00000000 0 0 0 1
5 1 0 1 00118233 00004004 0 00 00000000 1 04 00000000 0 1 0 0
5 1 0 1 00402283 00004008 0 00 00000000 1 05 00000004 0 1 1 0
5 1 0 1 00532023 0000400c 0 00 00000000 0 00 00000000 0 0 0 1
5 1 0 1 00532023 0000400c 0 00 00000000 1 00 00000000 0 0 1 0
5 1 0 1 00002003 00004010 0 00 00000000 1 00 00000000 0 1 1 0
5 1 0 1 00100313 00004014 0 00 00000000 1 06 00000001 0 1 0 0
6 1 0 1 12300393 00005000 0 00 00000000 1 07 00000123 0 1 0 0
6 0 0 1 fff5c513 00005004 0 00 00000000 0 07 00000123 0 1 0 0
6 0 0 1 fff5c513 00005008 0 00 00000000 0 07 00000123 0 1 0 0

//--- core_dec_top.f
core_pkg.sv
core_cpu_ctrl.sv
core_reg_file.sv
core_haz_chk.sv
core_dec_s.sv
core_dec_top.sv
tb_core_dec.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f core_dec_top.f --top-module tb_core_dec -o tb_core_dec

out=$(./obj_dir/tb_core_dec)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
exit 1

//--- tb_core_dec.sv
// testbench for the decode station top
// replays vectors from a data file and checks dec_out, dec_stall and dec2haz_cmd

`timescale 1ns/1ps

module tb_core_dec;

	// one line of the vector file
	typedef struct packed {
		logic [7:0]  test;
		logic        enb;
		logic        kill;
		logic        ack;
		logic [31:0] inst;
		logic [31:0] pc;
		logic        wb_we;
		logic [4:0]  wb_rd;
		logic [31:0] wb_data;
		logic        e_val;
		logic [4:0]  e_rd;
		logic [31:0] e_imm;
		logic [3:0]  e_alu;
		logic        e_we;
		logic        e_l1d;
		logic        e_stall;
	} vec_t;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               dec_enb;
	logic               dec_kill;
	logic               dec_l1i_ack;
	logic [31:0]        dec_inst;
	logic [31:0]        dec_pc;
	logic [31:0]        dec_pc_4;
	core_pkg::wb_t      wb;
	core_pkg::dec_out_t dec_out;
	core_pkg::haz_cmd_e dec2haz_cmd;
	logic               dec_stall;

	vec_t        vecs[$];
	logic [31:0] model [0:31];
	logic [31:0] lfsr_state;
	logic        loaded;
	int          limit = 80;
	int          cycles = 0;
	int          n_checks;
	int          n_errs;
	int          n_tests;
	int          test_errs;
	int          test_vecs;
	int          cur_test;
	int          cur_line;

	core_dec_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_enb     (dec_enb),
		.dec_kill    (dec_kill),
		.dec_inst    (dec_inst),
		.dec_pc      (dec_pc),
		.dec_pc_4    (dec_pc_4),
		.dec_l1i_ack (dec_l1i_ack),
		.wb          (wb),
		.dec_out     (dec_out),
		.dec2haz_cmd (dec2haz_cmd),
		.dec_stall   (dec_stall)
	);

	always #20 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: run went past %0d cycles without finishing", limit);
			$display("Regression failed");
			$finish;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one new lfsr bit per bit of the word
	task automatic draw_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	// register model read with x0 as zero and same-cycle write through
	function automatic logic [31:0] model_read(input logic [4:0] a, input vec_t v,
			input logic [31:0] data);
		if (a == 5'd0) begin
			return '0;
		end
		if (v.wb_we && (v.wb_rd == a)) begin
			return data;
		end
		return model[a];
	endfunction

	// registers an rv32i word reads, by major opcode
	function automatic core_pkg::haz_cmd_e sources_read(input logic [31:0] inst);
		core_pkg::haz_cmd_e s;
		case (inst[6:0])
			7'h67, 7'h03, 7'h13: s = core_pkg::HAZ_RS1;
			7'h63, 7'h23, 7'h33: s = core_pkg::HAZ_BOTH;
			default:             s = core_pkg::HAZ_NONE;
		endcase
		return s;
	endfunction

	// operand and link selects an rv32i word needs, by major opcode
	function automatic logic [5:0] operand_selects(input logic [31:0] inst);
		logic [6:0] op;
		logic [5:0] m;
		op = inst[6:0];
		m  = '0;
		// immediate as second operand, branches compare two registers instead
		m[core_pkg::MUX_SRC2_IMM] = (op == 7'h37) || (op == 7'h17) || (op == 7'h6f)
		                         || (op == 7'h67) || (op == 7'h03) || (op == 7'h23)
		                         || (op == 7'h13);
		// pc relative forms
		m[core_pkg::MUX_SRC1_PC] = (op == 7'h17) || (op == 7'h6f);
		// jumps link pc + 4
		m[core_pkg::MUX_RES_PC4] = (op == 7'h6f) || (op == 7'h67);
		return m;
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] got);
		n_checks++;
		if (exp !== got) begin
			n_errs++;
			test_errs++;
			$display("FAIL @ %0t: test %0d line %0d %s expected %h got %h",
				$time, cur_test, cur_line, what, exp, got);
		end
	endtask

	task automatic report_test();
		$display("test %0d %s: %0d vectors, %0d mismatches", cur_test,
			(test_errs == 0) ? "ok" : "with errors", test_vecs, test_errs);
		n_tests++;
		test_vecs = 0;
		test_errs = 0;
	endtask

	task automatic load_vectors();
		int               fd;
		int               cnt;
		logic [31:0]      f [0:15];
		logic [8*256-1:0] line_buf;
		vec_t             v;
		fd = $fopen("tb_core_dec_input.txt", "r");
		if (fd != 0) begin
			while ($fgets(line_buf, fd) != 0) begin
				cnt = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
				if (cnt == 16) begin
					v = {f[0][7:0], f[1][0], f[2][0], f[3][0], f[4], f[5], f[6][0],
						f[7][4:0], f[8], f[9][0], f[10][4:0], f[11], f[12][3:0],
						f[13][0], f[14][0], f[15][0]};
					vecs.push_back(v);
				end
			end
			$fclose(fd);
		end
		loaded = (fd != 0) && (vecs.size() != 0);
		limit = vecs.size() * 4 + 16 + 64;
	endtask

	// ----------------------------------------
	// one vector driven on the falling edge
	// ----------------------------------------

	task automatic run_vector(input vec_t v);
		logic [31:0]        data;
		logic [31:0]        exp_src1;
		logic [31:0]        exp_src2;
		logic [5:0]         exp_sel;
		core_pkg::haz_cmd_e exp_haz;
		data = v.wb_data;
		// register data for the source test comes from the lfsr
		if ((v.test == 8'd3) && v.wb_we) begin
			draw_word(data);
		end
		dec_enb     = v.enb;
		dec_kill    = v.kill;
		dec_l1i_ack = v.ack;
		dec_inst    = v.inst;
		dec_pc      = v.pc;
		dec_pc_4    = v.pc + 32'd4;
		wb.we       = v.wb_we;
		wb.rd       = v.wb_rd;
		wb.data     = data;
		exp_src1 = model_read(v.inst[19:15], v, data);
		exp_src2 = model_read(v.inst[24:20], v, data);
		exp_haz  = sources_read(v.inst);
		exp_sel  = operand_selects(v.inst);
		#10;
		check("dec_stall", 32'(v.e_stall), 32'(dec_stall));
		check("dec2haz_cmd", 32'(exp_haz), 32'(dec2haz_cmd));
		@(negedge clk);
		if (v.wb_we && (v.wb_rd != 5'd0)) begin
			model[v.wb_rd] = data;
		end
		check("val", 32'(v.e_val), 32'(dec_out.val));
		check("rd", 32'(v.e_rd), 32'(dec_out.rd));
		check("sx_imm", v.e_imm, dec_out.sx_imm);
		check("alu_op", 32'(v.e_alu), 32'(dec_out.ctrl.alu_op));
		check("we_reg_file", 32'(v.e_we), 32'(dec_out.ctrl.we_reg_file));
		check("l1d_req_val", 32'(v.e_l1d), 32'(dec_out.ctrl.l1d_req_val));
		if (v.e_val) begin
			check("src1", exp_src1, dec_out.src1);
			check("src2", exp_src2, dec_out.src2);
			check("pc", v.pc, dec_out.pc);
			check("pc_4", v.pc + 32'd4, dec_out.pc_4);
			check("haz_cmd", 32'(exp_haz), 32'(dec_out.haz_cmd));
			check("src2_imm", 32'(exp_sel[core_pkg::MUX_SRC2_IMM]),
				32'(dec_out.ctrl.mux_bus[core_pkg::MUX_SRC2_IMM]));
			check("src1_pc", 32'(exp_sel[core_pkg::MUX_SRC1_PC]),
				32'(dec_out.ctrl.mux_bus[core_pkg::MUX_SRC1_PC]));
			check("res_pc4", 32'(exp_sel[core_pkg::MUX_RES_PC4]),
				32'(dec_out.ctrl.mux_bus[core_pkg::MUX_RES_PC4]));
		end
		test_vecs++;
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		rst_n       = 1'b0;
		dec_enb     = 1'b0;
		dec_kill    = 1'b0;
		dec_l1i_ack = 1'b1;
		dec_inst    = '0;
		dec_pc      = '0;
		dec_pc_4    = '0;
		wb          = '0;
		lfsr_state  = 32'h4cc80558;
		n_checks    = 0;
		n_errs      = 0;
		n_tests     = 0;
		test_errs   = 0;
		test_vecs   = 0;
		cur_line    = 0;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		load_vectors();
		if (!loaded) begin
			$display("stimulus file tb_core_dec_input.txt could not be read or has no vectors");
			$display("Regression failed");
			$finish;
		end else begin
			repeat (16) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			cur_test = vecs[0].test;
			for (int i = 0; i < vecs.size(); i++) begin
				if (vecs[i].test != cur_test) begin
					report_test();
					cur_test = vecs[i].test;
				end
				cur_line = i + 1;
				run_vector(vecs[i]);
			end
			report_test();
			$display("tests %0d, checks %0d, mismatches %0d", n_tests, n_checks, n_errs);
			if (n_errs == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end

endmodule

//--- core_dec_top.sv
// decode station top, decoder, register file, hazard check
// and output register with the combined stall

`timescale 1ns/1ps

module core_dec_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dec_enb,
	input  logic               dec_kill,
	input  logic [31:0]        dec_inst,
	input  logic [31:0]        dec_pc,
	input  logic [31:0]        dec_pc_4,
	input  logic               dec_l1i_ack,
	input  core_pkg::wb_t      wb,
	output core_pkg::dec_out_t dec_out,
	output core_pkg::haz_cmd_e dec2haz_cmd,
	output logic               dec_stall
);

	core_pkg::dec_ctrl_t ctrl;
	core_pkg::imm_fmt_e  imm_fmt;
	core_pkg::haz_cmd_e  haz_cmd;
	logic [31:0]         src1;
	logic [31:0]         src2;
	logic                load_use;

	core_cpu_ctrl cpu_ctrl (
		.inst    (dec_inst),
		.ctrl    (ctrl),
		.imm_fmt (imm_fmt),
		.haz_cmd (haz_cmd)
	);

	core_reg_file reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.rs1   (dec_inst[19:15]),
		.rs2   (dec_inst[24:20]),
		.wb    (wb),
		.src1  (src1),
		.src2  (src2)
	);

	// checks against what is already in the decode register
	core_haz_chk haz_chk (
		.prev     (dec_out),
		.rs1      (dec_inst[19:15]),
		.rs2      (dec_inst[24:20]),
		.haz_cmd  (haz_cmd),
		.load_use (load_use)
	);

	core_dec_s dec_s (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec_enb  (dec_enb),
		.dec_kill (dec_kill),
		.load_use (load_use),
		.inst     (dec_inst),
		.pc       (dec_pc),
		.pc_4     (dec_pc_4),
		.ctrl     (ctrl),
		.imm_fmt  (imm_fmt),
		.haz_cmd  (haz_cmd),
		.src1     (src1),
		.src2     (src2),
		.dec_out  (dec_out)
	);

	assign dec2haz_cmd = haz_cmd;

	// no fetch ack or a load-use conflict
	assign dec_stall = !dec_l1i_ack || load_use;

endmodule

//--- core_dec_s.sv
// decode station output stage
// builds the immediate and registers the result for execute

`timescale 1ns/1ps

module core_dec_s (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                dec_enb,
	input  logic                dec_kill,
	input  logic                load_use,
	input  logic [31:0]         inst,
	input  logic [31:0]         pc,
	input  logic [31:0]         pc_4,
	input  core_pkg::dec_ctrl_t ctrl,
	input  core_pkg::imm_fmt_e  imm_fmt,
	input  core_pkg::haz_cmd_e  haz_cmd,
	input  logic [31:0]         src1,
	input  logic [31:0]         src2,
	output core_pkg::dec_out_t  dec_out
);

	logic [31:0] sx_imm;
	logic        bubble;

	// ----------------------------------------
	// immediate
	// ----------------------------------------

	always_comb begin
		case (imm_fmt)
			core_pkg::IMM_I: sx_imm = {{20{inst[31]}}, inst[31:20]};
			core_pkg::IMM_S: sx_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			core_pkg::IMM_B: sx_imm = {{19{inst[31]}}, inst[31], inst[7],
			                           inst[30:25], inst[11:8], 1'b0};
			core_pkg::IMM_U: sx_imm = {inst[31:12], 12'b0};
			core_pkg::IMM_J: sx_imm = {{11{inst[31]}}, inst[31], inst[19:12],
			                           inst[20], inst[30:21], 1'b0};
			default:         sx_imm = '0;
		endcase
	end

	// ----------------------------------------
	// output register
	// ----------------------------------------

	// kill wins, load-use turns a capture into a bubble
	assign bubble = dec_kill || (dec_enb && load_use);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_out <= '0;
		end else begin
			// payload just follows enable
			if (dec_enb) begin
				dec_out.src1   <= src1;
				dec_out.src2   <= src2;
				dec_out.sx_imm <= sx_imm;
				dec_out.pc     <= pc;
				dec_out.pc_4   <= pc_4;
			end
			if (bubble) begin
				dec_out.ctrl    <= '0;
				dec_out.rs1     <= '0;
				dec_out.rs2     <= '0;
				dec_out.rd      <= '0;
				dec_out.haz_cmd <= core_pkg::HAZ_NONE;
				dec_out.val     <= 1'b0;
			end else if (dec_enb) begin
				dec_out.ctrl    <= ctrl;
				dec_out.rs1     <= inst[19:15];
				dec_out.rs2     <= inst[24:20];
				dec_out.rd      <= inst[11:7];
				dec_out.haz_cmd <= haz_cmd;
				dec_out.val     <= 1'b1;
			end else begin
				// hold, only the valid bit drops
				dec_out.val <= 1'b0;
			end
		end
	end

	a_kill_clears_val: assert property (@(posedge clk) disable iff (!rst_n)
		dec_kill |=> !dec_out.val)
		else $error("dec_out.val set in the cycle after kill");

endmodule

//--- core_haz_chk.sv
// load-use check between the instruction in the decode register
// and the one coming in from fetch

`timescale 1ns/1ps

module core_haz_chk (
	input  core_pkg::dec_out_t prev,
	input  logic [4:0]         rs1,
	input  logic [4:0]         rs2,
	input  core_pkg::haz_cmd_e haz_cmd,
	output logic               load_use
);

	logic prev_load;
	logic use_rs1;
	logic use_rs2;
	logic hit_rs1;
	logic hit_rs2;

	// ----------------------------------------
	// producer side
	// ----------------------------------------

	// a valid load with a real destination
	assign prev_load = prev.val
	                 && prev.ctrl.l1d_req_val
	                 && !prev.ctrl.l1d_req_cop
	                 && (prev.rd != 5'd0);

	// ----------------------------------------
	// consumer side
	// ----------------------------------------

	assign use_rs1 = (haz_cmd == core_pkg::HAZ_RS1) || (haz_cmd == core_pkg::HAZ_BOTH);
	assign use_rs2 = (haz_cmd == core_pkg::HAZ_RS2) || (haz_cmd == core_pkg::HAZ_BOTH);

	assign hit_rs1 = use_rs1 && (rs1 == prev.rd);
	assign hit_rs2 = use_rs2 && (rs2 == prev.rd);

	assign load_use = prev_load && (hit_rs1 || hit_rs2);

	// the load test above relies on a store always carrying a cache request
	always_comb begin
		if (prev.ctrl.l1d_req_cop) begin
			a_cop_has_req: assert (prev.ctrl.l1d_req_val)
				else $error("store flag without a data cache request in the decode register");
		end
	end

endmodule

//--- core_reg_file.sv
// 32 x 32 register file, two read ports and one write port
// x0 reads zero, a write in the same cycle bypasses to the reads

`timescale 1ns/1ps

module core_reg_file (
	input  logic          clk,
	input  logic          rst_n,
	input  logic [4:0]    rs1,
	input  logic [4:0]    rs2,
	input  core_pkg::wb_t wb,
	output logic [31:0]   src1,
	output logic [31:0]   src2
);

	logic [31:0] regs [1:31];

	// read with x0 and write-through handling
	function automatic logic [31:0] rd_port(input logic [4:0] addr);
		logic [31:0] data;
		if (addr == 5'd0) begin
			data = '0;
		end else if (wb.we && (wb.rd == addr)) begin
			data = wb.data;
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && (wb.rd != 5'd0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign src1 = rd_port(rs1);
	assign src2 = rd_port(rs2);

	// x0 stays zero on both ports, also right after a write aimed at it
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		((rs1 == 5'd0) |-> (src1 == '0)) and ((rs2 == 5'd0) |-> (src2 == '0)))
		else $error("x0 read returned nonzero");

endmodule

//--- core_cpu_ctrl.sv
// instruction decoder of the decode station
// turns an rv32i word into execute and data cache controls

`timescale 1ns/1ps

module core_cpu_ctrl (
	input  logic [31:0]         inst,
	output core_pkg::dec_ctrl_t ctrl,
	output core_pkg::imm_fmt_e  imm_fmt,
	output core_pkg::haz_cmd_e  haz_cmd
);

	core_pkg::opcode_e opc;
	logic [2:0]        funct3;
	logic              alt;

	// alu op from funct3, alt is bit 30 (sub / sra)
	function automatic core_pkg::alu_op_e alu_from_f3(
		input logic [2:0] f3,
		input logic       alt_bit,
		input logic       reg_op
	);
		core_pkg::alu_op_e op;
		case (f3)
			core_pkg::F3_ADD:  op = (reg_op && alt_bit) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			core_pkg::F3_SLL:  op = core_pkg::ALU_SLL;
			core_pkg::F3_SLT:  op = core_pkg::ALU_SLT;
			core_pkg::F3_SLTU: op = core_pkg::ALU_SLTU;
			core_pkg::F3_XOR:  op = core_pkg::ALU_XOR;
			core_pkg::F3_SR:   op = alt_bit ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			core_pkg::F3_OR:   op = core_pkg::ALU_OR;
			core_pkg::F3_AND:  op = core_pkg::ALU_AND;
			default:           op = core_pkg::ALU_ADD;
		endcase
		return op;
	endfunction

	// compressed space is not decoded here
	assign opc    = (inst[1:0] == 2'b11) ? core_pkg::opcode_e'(inst[6:0])
	                                     : core_pkg::OPC_ILLEGAL;
	assign funct3 = inst[14:12];
	assign alt    = inst[30];

	always_comb begin
		ctrl    = '0;
		imm_fmt = core_pkg::IMM_NONE;
		haz_cmd = core_pkg::HAZ_NONE;
		case (opc)
			core_pkg::OPC_LUI: begin
				ctrl.alu_op                          = core_pkg::ALU_PASS_B;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				imm_fmt                              = core_pkg::IMM_U;
			end
			core_pkg::OPC_AUIPC: begin
				ctrl.alu_op                          = core_pkg::ALU_ADD;
				ctrl.mux_bus[core_pkg::MUX_SRC1_PC]  = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				imm_fmt                              = core_pkg::IMM_U;
			end
			core_pkg::OPC_JAL: begin
				// target is pc + imm, link is pc + 4
				ctrl.alu_op                          = core_pkg::ALU_ADD;
				ctrl.mux_bus[core_pkg::MUX_SRC1_PC]  = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_RES_PC4]  = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_JUMP]     = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				imm_fmt                              = core_pkg::IMM_J;
			end
			core_pkg::OPC_JALR: begin
				ctrl.alu_op                          = core_pkg::ALU_ADD;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_RES_PC4]  = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_JUMP]     = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				imm_fmt                              = core_pkg::IMM_I;
				haz_cmd                              = core_pkg::HAZ_RS1;
			end
			core_pkg::OPC_BRANCH: begin
				// compare type from funct3 bits 2:1
				case (funct3[2:1])
					2'b10:   ctrl.alu_op = core_pkg::ALU_SLT;
					2'b11:   ctrl.alu_op = core_pkg::ALU_SLTU;
					default: ctrl.alu_op = core_pkg::ALU_SUB;
				endcase
				ctrl.alu_cnd                       = funct3;
				ctrl.mux_bus[core_pkg::MUX_BRANCH] = 1'b1;
				imm_fmt                            = core_pkg::IMM_B;
				haz_cmd                            = core_pkg::HAZ_BOTH;
			end
			core_pkg::OPC_LOAD: begin
				ctrl.alu_op                          = core_pkg::ALU_ADD;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.mux_bus[core_pkg::MUX_RES_MEM]  = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				ctrl.wb_sx_op                        = funct3;
				ctrl.l1d_req_val                     = 1'b1;
				ctrl.l1d_req_size                    = {1'b0, funct3[1:0]};
				imm_fmt                              = core_pkg::IMM_I;
				haz_cmd                              = core_pkg::HAZ_RS1;
			end
			core_pkg::OPC_STORE: begin
				ctrl.alu_op                          = core_pkg::ALU_ADD;
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.l1d_req_val                     = 1'b1;
				ctrl.l1d_req_cop                     = 1'b1;
				ctrl.l1d_req_size                    = {1'b0, funct3[1:0]};
				imm_fmt                              = core_pkg::IMM_S;
				haz_cmd                              = core_pkg::HAZ_BOTH;
			end
			core_pkg::OPC_OP_IMM: begin
				ctrl.alu_op                          = alu_from_f3(funct3, alt, 1'b0);
				ctrl.mux_bus[core_pkg::MUX_SRC2_IMM] = 1'b1;
				ctrl.we_reg_file                     = 1'b1;
				imm_fmt                              = core_pkg::IMM_I;
				haz_cmd                              = core_pkg::HAZ_RS1;
			end
			core_pkg::OPC_OP: begin
				ctrl.alu_op      = alu_from_f3(funct3, alt, 1'b1);
				ctrl.we_reg_file = 1'b1;
				haz_cmd          = core_pkg::HAZ_BOTH;
			end
			default: begin
				// illegal, leave everything zero
				ctrl = '0;
			end
		endcase
	end

endmodule

//--- core_pkg.sv
// shared types and decode constants for the rv32i decode station
// enums, control structs and the mux_bus bit map

package core_pkg;

	// ----------------------------------------
	// enums
	// ----------------------------------------

	// rv32i major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		OPC_LUI     = 7'b0110111,
		OPC_AUIPC   = 7'b0010111,
		OPC_JAL     = 7'b1101111,
		OPC_JALR    = 7'b1100111,
		OPC_BRANCH  = 7'b1100011,
		OPC_LOAD    = 7'b0000011,
		OPC_STORE   = 7'b0100011,
		OPC_OP_IMM  = 7'b0010011,
		OPC_OP      = 7'b0110011,
		OPC_ILLEGAL = 7'b0000000
	} opcode_e;

	// execute operation
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} imm_fmt_e;

	// which register sources the instruction reads
	typedef enum logic [1:0] {
		HAZ_NONE = 2'd0,
		HAZ_RS1  = 2'd1,
		HAZ_RS2  = 2'd2,
		HAZ_BOTH = 2'd3
	} haz_cmd_e;

	// ----------------------------------------
	// decode constants
	// ----------------------------------------

	// funct3 of the alu group
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// bit positions in mux_bus
	localparam int MUX_SRC2_IMM = 0;
	localparam int MUX_SRC1_PC  = 1;
	localparam int MUX_RES_PC4  = 2;
	localparam int MUX_RES_MEM  = 3;
	localparam int MUX_BRANCH   = 4;
	localparam int MUX_JUMP     = 5;

	// ----------------------------------------
	// structs
	// ----------------------------------------

	typedef struct packed {
		logic [2:0] wb_sx_op;
		logic [5:0] mux_bus;
		logic       we_reg_file;
		alu_op_e    alu_op;
		logic [2:0] alu_cnd;
		logic       l1d_req_val;
		logic       l1d_req_cop;
		logic [2:0] l1d_req_size;
	} dec_ctrl_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_t;

	// everything handed on to execute
	typedef struct packed {
		dec_ctrl_t   ctrl;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] sx_imm;
		logic [31:0] pc;
		logic [31:0] pc_4;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		haz_cmd_e    haz_cmd;
		logic        val;
	} dec_out_t;

endpackage
